/* src/eth_rx_cfg.svh */
`ifndef ETH_RX_CFG_SVH
`define ETH_RX_CFG_SVH

// XGMII word width and lane count
`define ETH_RX_DATA_W 32
`define ETH_RX_NBYTES 4

// Statistics counters and register space
`define ETH_RX_CNT_W 32
`define ETH_RX_AXIL_ADDR_W 4

`endif

/* src/xgmii_pkg.sv */
`include "eth_rx_cfg.svh"

package xgmii_pkg;

    // Control characters seen with the lane control bit set
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hFB;
    localparam logic [7:0] RS_TERM  = 8'hFD;
    localparam logic [7:0] RS_ERROR = 8'hFE;

    // Preamble filler and start-of-frame delimiter
    localparam logic [7:0] ETH_PREAMBLE = 8'h55;
    localparam logic [7:0] ETH_SFD      = 8'hD5;

    // One PHY word, lane 0 in the low byte
    typedef struct packed {
        logic [`ETH_RX_NBYTES-1:0][7:0] data;
        logic [`ETH_RX_NBYTES-1:0]      ctrl;
        logic                           valid;
    } xgmii_word_t;

endpackage

/* src/axis_pkg.sv */
`include "eth_rx_cfg.svh"

package axis_pkg;

    // Received frame stream, no back-pressure
    typedef struct packed {
        logic [`ETH_RX_DATA_W-1:0] tdata;
        logic [`ETH_RX_NBYTES-1:0] tkeep;
        logic                      tvalid;
        logic                      tlast;
        logic                      tuser;
    } rx_axis_t;

    // AXI4-Lite read address and read data channels
    typedef struct packed {
        logic [`ETH_RX_AXIL_ADDR_W-1:0] araddr;
        logic                           arvalid;
    } axil_ar_t;

    typedef struct packed {
        logic [`ETH_RX_DATA_W-1:0] rdata;
        logic [1:0]                rresp;
        logic                      rvalid;
    } axil_r_t;

    // Statistics register map
    localparam logic [`ETH_RX_AXIL_ADDR_W-1:0] STAT_GOOD_ADDR   = 'h0;
    localparam logic [`ETH_RX_AXIL_ADDR_W-1:0] STAT_BADFCS_ADDR = 'h4;
    localparam logic [`ETH_RX_AXIL_ADDR_W-1:0] STAT_ABORT_ADDR  = 'h8;

endpackage

/* src/rx_term_detect.sv */
`include "eth_rx_cfg.svh"

module rx_term_detect (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  xgmii_pkg::xgmii_word_t    i_xgmii,
    output xgmii_pkg::xgmii_word_t    o_word,
    output logic [`ETH_RX_NBYTES-1:0] o_term_loc
);

    logic [`ETH_RX_NBYTES-1:0][7:0] data_q;
    logic [`ETH_RX_NBYTES-1:0]      ctrl_q;
    logic                           valid_q;
    logic [`ETH_RX_NBYTES-1:0]      term_any;
    logic [`ETH_RX_NBYTES-1:0]      term_low;

    // Terminate candidates, then isolate the lowest one
    always_comb begin
        for (int l = 0; l < `ETH_RX_NBYTES; l++) begin
            term_any[l] = i_xgmii.ctrl[l] && (i_xgmii.data[l] == xgmii_pkg::RS_TERM);
        end
        term_low = term_any & (~term_any + 1'b1);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q    <= 1'b0;
            o_term_loc <= '0;
        end else begin
            valid_q    <= i_xgmii.valid;
            o_term_loc <= i_xgmii.valid ? term_low : '0;
        end
    end

    // Word payload only moves on a PHY strobe
    always_ff @(posedge i_clk) begin
        if (i_xgmii.valid) begin
            data_q <= i_xgmii.data;
            ctrl_q <= i_xgmii.ctrl;
        end
    end

    assign o_word = '{data: data_q, ctrl: ctrl_q, valid: valid_q};

endmodule

/* src/rx_crc32.sv */
`include "eth_rx_cfg.svh"

module rx_crc32 (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic [`ETH_RX_DATA_W-1:0] i_data,
    input  logic [`ETH_RX_NBYTES-1:0] i_byte_en,
    output logic [31:0]               o_crc
);

    // Reflected IEEE 802.3 polynomial
    localparam logic [31:0] POLY = 32'hEDB88320;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // Fold enabled bytes, lane 0 first, one bit at a time
    always_comb begin
        crc_next = crc_q;
        for (int b = 0; b < `ETH_RX_NBYTES; b++) begin
            if (i_byte_en[b]) begin
                crc_next = crc_next ^ {24'h0, i_data[b*8 +: 8]};
                for (int k = 0; k < 8; k++) begin
                    if (crc_next[0]) begin
                        crc_next = (crc_next >> 1) ^ POLY;
                    end else begin
                        crc_next = crc_next >> 1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            crc_q <= '1;
        end else begin
            crc_q <= crc_next;
        end
    end

    // Includes this cycle's bytes so the MAC can compare on the terminate beat
    assign o_crc = ~crc_next;

    // The MAC only ever hands over a run of bytes starting at lane 0
    a_byte_en_contig: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (((i_byte_en + 1'b1) & i_byte_en) == '0)
    );

endmodule

/* src/rx_mac.sv */
`include "eth_rx_cfg.svh"

module rx_mac (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  xgmii_pkg::xgmii_word_t    i_word,
    input  logic [`ETH_RX_NBYTES-1:0] i_term_loc,
    output axis_pkg::rx_axis_t        o_axis,
    output logic                      o_frame_done,
    output logic                      o_frame_good,
    output logic                      o_frame_badfcs
);

    typedef enum logic {
        ST_IDLE,
        ST_DATA
    } state_t;

    state_t state_q;
    state_t state_d;

    // Set for the word after the start, which carries preamble and SFD
    logic pre_q;

    logic [`ETH_RX_DATA_W-1:0] cur_data;
    logic [`ETH_RX_DATA_W-1:0] del_data_q;
    logic [`ETH_RX_NBYTES-1:0] del_keep_q;
    logic [`ETH_RX_NBYTES-1:0] term_keep;
    logic [`ETH_RX_NBYTES-1:0] crc_en;
    logic [31:0]               fcs_rx;
    logic [31:0]               crc_calc;
    logic                      start_found;
    logic                      term_found;
    logic                      abort;
    logic                      fcs_ok;
    axis_pkg::rx_axis_t        axis;

    assign cur_data    = i_word.data;
    assign start_found = i_word.valid && i_word.ctrl[0]
                         && (cur_data[7:0] == xgmii_pkg::RS_START);
    assign term_found  = |i_term_loc;

    // Lanes below the terminate, or all lanes when there is none
    assign term_keep = i_term_loc - 1'b1;

    // Any other control character ahead of the terminate kills the frame
    assign abort = pre_q ? (|i_word.ctrl) : (|(i_word.ctrl & term_keep));

    always_comb begin
        state_d     = state_q;
        axis        = '0;
        axis.tdata  = cur_data;
        if (state_q == ST_IDLE) begin
            if (start_found) begin
                state_d = ST_DATA;
            end
        end else if (i_word.valid) begin
            if (abort) begin
                axis.tvalid = 1'b1;
                axis.tlast  = 1'b1;
                state_d     = ST_IDLE;
            end else if (term_found) begin
                axis.tvalid = 1'b1;
                axis.tlast  = 1'b1;
                axis.tkeep  = term_keep;
                axis.tuser  = fcs_ok;
                state_d     = ST_IDLE;
            end else if (!pre_q) begin
                axis.tvalid = 1'b1;
                axis.tkeep  = '1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q    <= ST_IDLE;
            pre_q      <= 1'b0;
            del_keep_q <= '0;
        end else if (i_word.valid) begin
            state_q    <= state_d;
            pre_q      <= (state_q == ST_IDLE) && start_found;
            del_keep_q <= axis.tkeep;
        end
    end

    // Previous word, needed when the FCS straddles two words
    always_ff @(posedge i_clk) begin
        if (i_word.valid) begin
            del_data_q <= cur_data;
        end
    end

    // Received FCS is the four bytes right before the terminate
    always_comb begin
        case (i_term_loc)
            4'b0001: fcs_rx = del_data_q;
            4'b0010: fcs_rx = {cur_data[7:0], del_data_q[31:8]};
            4'b0100: fcs_rx = {cur_data[15:0], del_data_q[31:16]};
            4'b1000: fcs_rx = {cur_data[23:0], del_data_q[31:24]};
            default: fcs_rx = cur_data;
        endcase
    end

    // CRC runs one word behind; on the terminate beat stop short of the FCS
    always_comb begin
        if (!i_word.valid) begin
            crc_en = '0;
        end else if (term_found) begin
            crc_en = term_keep;
        end else begin
            crc_en = del_keep_q;
        end
    end

    rx_crc32 crc_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset || (state_q == ST_IDLE)),
        .i_data    (del_data_q),
        .i_byte_en (crc_en),
        .o_crc     (crc_calc)
    );

    assign fcs_ok = (crc_calc == fcs_rx);

    assign o_axis         = axis;
    assign o_frame_done   = axis.tvalid && axis.tlast;
    assign o_frame_good   = o_frame_done && axis.tuser;
    assign o_frame_badfcs = o_frame_done && term_found && !abort && !fcs_ok;

    // Tail keep and FCS alignment rely on a single terminate lane
    a_term_onehot: assert property (
        @(posedge i_clk) disable iff (i_reset) $onehot0(i_term_loc)
    );

    a_term_ctrl: assert property (
        @(posedge i_clk) disable iff (i_reset) ((i_term_loc & ~i_word.ctrl) == '0)
    );

endmodule

/* src/rx_stats.sv */
`include "eth_rx_cfg.svh"

module rx_stats (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_frame_done,
    input  logic               i_frame_good,
    input  logic               i_frame_badfcs,
    input  axis_pkg::axil_ar_t i_axil_ar,
    output logic               o_axil_arready,
    output axis_pkg::axil_r_t  o_axil_r,
    input  logic               i_axil_rready
);

    logic [`ETH_RX_CNT_W-1:0]  cnt_good_q;
    logic [`ETH_RX_CNT_W-1:0]  cnt_badfcs_q;
    logic [`ETH_RX_CNT_W-1:0]  cnt_abort_q;
    logic [`ETH_RX_DATA_W-1:0] rd_mux;
    logic [`ETH_RX_DATA_W-1:0] rdata_q;
    logic                      rvalid_q;
    logic                      ar_fire;

    // Stick at full scale instead of wrapping
    function automatic logic [`ETH_RX_CNT_W-1:0] sat_inc(input logic [`ETH_RX_CNT_W-1:0] v);
        sat_inc = (&v) ? v : v + 1'b1;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt_good_q   <= '0;
            cnt_badfcs_q <= '0;
            cnt_abort_q  <= '0;
        end else if (i_frame_done) begin
            if (i_frame_good) begin
                cnt_good_q <= sat_inc(cnt_good_q);
            end else if (i_frame_badfcs) begin
                cnt_badfcs_q <= sat_inc(cnt_badfcs_q);
            end else begin
                cnt_abort_q <= sat_inc(cnt_abort_q);
            end
        end
    end

    // One read in flight at a time
    assign o_axil_arready = !rvalid_q;
    assign ar_fire        = i_axil_ar.arvalid && o_axil_arready;

    // Unmapped addresses read as zero
    always_comb begin
        case (i_axil_ar.araddr)
            axis_pkg::STAT_GOOD_ADDR:   rd_mux = cnt_good_q;
            axis_pkg::STAT_BADFCS_ADDR: rd_mux = cnt_badfcs_q;
            axis_pkg::STAT_ABORT_ADDR:  rd_mux = cnt_abort_q;
            default:                    rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end else if (i_axil_rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ar_fire) begin
            rdata_q <= rd_mux;
        end
    end

    assign o_axil_r = '{rdata: rdata_q, rresp: 2'b00, rvalid: rvalid_q};

    // Each frame end carries exactly one outcome
    a_outcome_single: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_frame_good || i_frame_badfcs) |-> (i_frame_done && !(i_frame_good && i_frame_badfcs))
    );

endmodule

/* src/eth_rx_top.sv */
`include "eth_rx_cfg.svh"

module eth_rx_top (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  xgmii_pkg::xgmii_word_t i_xgmii,
    output axis_pkg::rx_axis_t     o_axis,
    input  axis_pkg::axil_ar_t     i_axil_ar,
    output logic                   o_axil_arready,
    output axis_pkg::axil_r_t      o_axil_r,
    input  logic                   i_axil_rready
);

    xgmii_pkg::xgmii_word_t    word;
    logic [`ETH_RX_NBYTES-1:0] term_loc;
    logic                      frame_done;
    logic                      frame_good;
    logic                      frame_badfcs;

    // PHY word register and terminate lane
    rx_term_detect term_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_xgmii    (i_xgmii),
        .o_word     (word),
        .o_term_loc (term_loc)
    );

    rx_mac mac_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_word         (word),
        .i_term_loc     (term_loc),
        .o_axis         (o_axis),
        .o_frame_done   (frame_done),
        .o_frame_good   (frame_good),
        .o_frame_badfcs (frame_badfcs)
    );

    // Frame outcome counters on the register port
    rx_stats stats_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_frame_done   (frame_done),
        .i_frame_good   (frame_good),
        .i_frame_badfcs (frame_badfcs),
        .i_axil_ar      (i_axil_ar),
        .o_axil_arready (o_axil_arready),
        .o_axil_r       (o_axil_r),
        .i_axil_rready  (i_axil_rready)
    );

endmodule

/* sim/rx_checker.sv */
`include "eth_rx_cfg.svh"

module rx_checker (
    input logic               i_clk,
    input logic               i_reset,
    input axis_pkg::rx_axis_t i_axis
);

    // Expected frames, filled ahead of the traffic
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    logic       exp_tuser [$];

    int build_len   = 0;
    int frame_idx   = 0;
    int byte_idx    = 0;
    int frame_pos   = 0;
    int stream_errs = 0;
    int value_errs  = 0;

    task automatic add_byte(input logic [7:0] b);
        exp_bytes.push_back(b);
        build_len++;
    endtask

    task automatic close_frame(input logic tuser);
        exp_len.push_back(build_len);
        exp_tuser.push_back(tuser);
        build_len = 0;
    endtask

    function automatic int frames_pending();
        return exp_len.size() - frame_idx;
    endfunction

    function automatic void show_mismatch(input string name, input logic [31:0] exp,
                                          input logic [31:0] act);
        $display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
    endfunction

    // Register and state values handed over by the testbench
    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            show_mismatch(name, exp, act);
            value_errs++;
        end
    endtask

    // Beats are stable between rising edges
    always @(negedge i_clk) begin
        int                        remaining;
        logic                      exp_last;
        logic [`ETH_RX_NBYTES-1:0] exp_keep;
        if (!i_reset && i_axis.tvalid) begin
            if (frame_idx >= exp_len.size()) begin
                $display("error at %0t: stream beat with no frame expected", $time);
                stream_errs++;
            end else begin
                remaining = exp_len[frame_idx] - frame_pos;
                // Fewer than a word left means this is the tail beat
                exp_last = remaining < `ETH_RX_NBYTES;
                exp_keep = exp_last ? 4'((1 << remaining) - 1) : 4'hF;
                if (i_axis.tkeep !== exp_keep) begin
                    show_mismatch("tkeep", 32'(exp_keep), 32'(i_axis.tkeep));
                    stream_errs++;
                end
                if (i_axis.tlast !== exp_last) begin
                    show_mismatch("tlast", 32'(exp_last), 32'(i_axis.tlast));
                    stream_errs++;
                end
                for (int l = 0; l < `ETH_RX_NBYTES; l++) begin
                    if (exp_keep[l]) begin
                        if (i_axis.tdata[l*8 +: 8] !== exp_bytes[byte_idx]) begin
                            show_mismatch($sformatf("tdata lane %0d", l),
                                          32'(exp_bytes[byte_idx]), 32'(i_axis.tdata[l*8 +: 8]));
                            stream_errs++;
                        end
                        byte_idx++;
                        frame_pos++;
                    end
                end
                if (exp_last) begin
                    if (i_axis.tuser !== exp_tuser[frame_idx]) begin
                        show_mismatch("tuser", 32'(exp_tuser[frame_idx]), 32'(i_axis.tuser));
                        stream_errs++;
                    end
                    frame_idx++;
                    frame_pos = 0;
                end
            end
        end
    end

endmodule

/* sim/tb_eth_rx.sv */
`include "eth_rx_cfg.svh"

module tb_eth_rx;

    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_FRAMES = 12;

    typedef struct packed {
        int   len;
        logic corrupt;
        int   abort_at;
        int   gaps;
        logic good;
    } frame_entry_t;

    // Payload length, bad FCS, error byte (-1 none), idle words after, expected tuser
    frame_entry_t frames [NUM_FRAMES] = '{
        '{60, 1'b0, -1, 1, 1'b1},
        '{61, 1'b0, -1, 0, 1'b1},
        '{62, 1'b0, -1, 2, 1'b1},
        '{63, 1'b0, -1, 1, 1'b1},
        '{64, 1'b0, -1, 0, 1'b1},
        '{65, 1'b1, -1, 1, 1'b0},
        '{66, 1'b0, -1, 3, 1'b1},
        '{67, 1'b0, -1, 0, 1'b1},
        '{62, 1'b0, 21, 1, 1'b0},
        '{64, 1'b1, -1, 2, 1'b0},
        '{63, 1'b0,  0, 1, 1'b0},
        '{60, 1'b0, -1, 1, 1'b1}
    };

    logic                   i_clk;
    logic                   i_reset;
    xgmii_pkg::xgmii_word_t i_xgmii;
    axis_pkg::rx_axis_t     o_axis;
    axis_pkg::axil_ar_t     i_axil_ar;
    logic                   o_axil_arready;
    axis_pkg::axil_r_t      o_axil_r;
    logic                   i_axil_rready;
    logic [8:0]             lanes [$];
    integer                 seed;
    int                     n_good;
    int                     n_badfcs;
    int                     n_abort;

    eth_rx_top dut_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii        (i_xgmii),
        .o_axis         (o_axis),
        .i_axil_ar      (i_axil_ar),
        .o_axil_arready (o_axil_arready),
        .o_axil_r       (o_axil_r),
        .i_axil_rready  (i_axil_rready)
    );

    rx_checker chk_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_axis  (o_axis)
    );

    always #2 i_clk = ~i_clk;

    // Reference FCS, one byte at a time, reflected polynomial
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("errors: stream %0d, register and state %0d", chk_i.stream_errs,
                 chk_i.value_errs);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Four lanes from the lane queue, sometimes after a strobe gap
    task automatic drive_word(input int first);
        xgmii_pkg::xgmii_word_t w;
        w.valid = 1'b1;
        for (int l = 0; l < `ETH_RX_NBYTES; l++) begin
            w.ctrl[l] = lanes[first + l][8];
            w.data[l] = lanes[first + l][7:0];
        end
        if (($random(seed) & 7) == 0) begin
            @(negedge i_clk);
            i_xgmii.valid = 1'b0;
        end
        @(negedge i_clk);
        i_xgmii = w;
    endtask

    task automatic send_frame(input frame_entry_t f);
        logic [7:0]  bytes [$];
        logic [31:0] crc;
        int          kept;
        crc = '1;
        for (int i = 0; i < f.len; i++) begin
            bytes.push_back(8'($random(seed)));
            crc = crc_byte(crc, bytes[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            bytes.push_back(crc[i*8 +: 8]);
        end
        if (f.corrupt) begin
            bytes[f.len + 1] ^= 8'h5A;
        end
        // An error character drops its whole word and everything after
        kept = (f.abort_at < 0) ? bytes.size() : (f.abort_at / 4) * 4;
        for (int i = 0; i < kept; i++) begin
            chk_i.add_byte(bytes[i]);
        end
        chk_i.close_frame(f.good);
        lanes = {};
        lanes.push_back({1'b1, xgmii_pkg::RS_START});
        repeat (6) lanes.push_back({1'b0, xgmii_pkg::ETH_PREAMBLE});
        lanes.push_back({1'b0, xgmii_pkg::ETH_SFD});
        foreach (bytes[i]) begin
            lanes.push_back({1'b0, bytes[i]});
        end
        lanes.push_back({1'b1, xgmii_pkg::RS_TERM});
        while (lanes.size() % 4 != 0) begin
            lanes.push_back({1'b1, xgmii_pkg::RS_IDLE});
        end
        repeat (f.gaps * 4) lanes.push_back({1'b1, xgmii_pkg::RS_IDLE});
        if (f.abort_at >= 0) begin
            lanes[8 + f.abort_at] = {1'b1, xgmii_pkg::RS_ERROR};
        end
        for (int w = 0; w < lanes.size(); w += 4) begin
            drive_word(w);
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp, input string name);
        int          n;
        logic [31:0] held;
        n = 0;
        @(negedge i_clk);
        i_axil_ar = '{araddr: addr, arvalid: 1'b1};
        while (!o_axil_arready) begin
            if (n == WAIT_LIMIT) begin
                stop_on_timeout("read address ready");
            end
            n++;
            @(negedge i_clk);
        end
        @(negedge i_clk);
        i_axil_ar.arvalid = 1'b0;
        n = 0;
        while (!o_axil_r.rvalid) begin
            if (n == WAIT_LIMIT) begin
                stop_on_timeout("read data valid");
            end
            n++;
            @(negedge i_clk);
        end
        held = o_axil_r.rdata;
        // Response sits still until the host takes it
        repeat (2) begin
            @(negedge i_clk);
            chk_i.compare({"rvalid held, ", name}, 32'd1, 32'(o_axil_r.rvalid));
            chk_i.compare({"rdata held, ", name}, held, o_axil_r.rdata);
        end
        chk_i.compare({"rdata, ", name}, exp, held);
        chk_i.compare({"rresp, ", name}, 32'd0, 32'(o_axil_r.rresp));
        i_axil_rready = 1'b1;
        @(negedge i_clk);
        i_axil_rready = 1'b0;
    endtask

    task automatic wait_stream_done();
        int n;
        n = 0;
        while (chk_i.frames_pending() != 0) begin
            if (n == WAIT_LIMIT) begin
                stop_on_timeout("the remaining stream frames");
            end
            n++;
            @(negedge i_clk);
        end
    endtask

    initial begin
        seed          = 32'h6b76de23;
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_xgmii       = '{data: {4{xgmii_pkg::RS_IDLE}}, ctrl: 4'hF, valid: 1'b0};
        i_axil_ar     = '0;
        i_axil_rready = 1'b0;
        n_good        = 0;
        n_badfcs      = 0;
        n_abort       = 0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);
        chk_i.compare("tvalid after reset", 32'd0, 32'(o_axis.tvalid));
        chk_i.compare("arready after reset", 32'd1, 32'(o_axil_arready));
        read_reg(axis_pkg::STAT_GOOD_ADDR, 32'd0, "good count after reset");
        read_reg(axis_pkg::STAT_BADFCS_ADDR, 32'd0, "bad FCS count after reset");
        read_reg(axis_pkg::STAT_ABORT_ADDR, 32'd0, "abort count after reset");
        foreach (frames[i]) begin
            send_frame(frames[i]);
            if (frames[i].abort_at >= 0) begin
                n_abort++;
            end else if (frames[i].corrupt) begin
                n_badfcs++;
            end else begin
                n_good++;
            end
        end
        wait_stream_done();
        read_reg(axis_pkg::STAT_GOOD_ADDR, 32'(n_good), "good count");
        read_reg(axis_pkg::STAT_BADFCS_ADDR, 32'(n_badfcs), "bad FCS count");
        read_reg(axis_pkg::STAT_ABORT_ADDR, 32'(n_abort), "abort count");
        read_reg(4'hC, 32'd0, "unmapped address");
        $display("errors: stream %0d, register and state %0d", chk_i.stream_errs,
                 chk_i.value_errs);
        if (chk_i.stream_errs + chk_i.value_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+src
src/xgmii_pkg.sv
src/axis_pkg.sv
src/rx_term_detect.sv
src/rx_crc32.sv
src/rx_mac.sv
src/rx_stats.sv
src/eth_rx_top.sv
sim/rx_checker.sv
sim/tb_eth_rx.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_eth_rx -o tb_eth_rx_sim &&
obj_dir/tb_eth_rx_sim > sim.log 2>&1 ;
cat sim.log &&
! grep -q "TEST RESULT: FAIL" sim.log &&
grep -q "TEST RESULT: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
